// ==== vlog.f ====
+incdir+source
source/synth_pkg.sv
source/uart_receiver.sv
source/midi_parser.sv
source/note_oscillator.sv
source/i2s_transmitter.sv
source/synth_top.sv
verif/synth_props.sv
verif/synth_checker.sv
verif/synth_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the synth testbench, then scan the log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module synth_tb \
  -o synth_sim || { echo "build failed"; exit 1; }
./obj_dir/synth_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// ==== verif/synth_tb.sv ====
`include "synth_defines.svh"

module synth_tb
  import synth_pkg::*;
();

  localparam int BYTE_CYCLES  = 11 * `CLKS_PER_BIT; // start, 8 data, stop, idle
  localparam int FRAME_CYCLES = 4 * `BCLK_DIV * `SLOT_BITS;
  localparam int WAIT_FRAMES  = 8;
  localparam int NUM_BYTES    = 54;
  localparam int NUM_WAITS    = 19;
  localparam int MAX_CYCLES   = NUM_BYTES * BYTE_CYCLES +
                                NUM_WAITS * (WAIT_FRAMES + 1) * FRAME_CYCLES + 20000;

  localparam logic [3:0] CHANNEL       = 4'(`MIDI_CHANNEL);
  localparam logic [3:0] OTHER_CHANNEL = CHANNEL + 4'd1;

  logic  clock_50_000_000;
  logic  rst;
  logic  midi_rx;
  logic  bit_clock;
  logic  word_select;
  logic  serial_data;

  logic  model_sounding = 1'b0;
  note_t model_note = '0;
  int    other_errors = 0;
  int    cycle_count = 0;

  synth_top UUT (
    .clock_50_000_000 (clock_50_000_000),
    .rst              (rst),
    .midi_rx          (midi_rx),
    .bit_clock        (bit_clock),
    .word_select      (word_select),
    .serial_data      (serial_data)
  );

  synth_checker frame_check (
    .clock_50_000_000 (clock_50_000_000),
    .rst              (rst),
    .bit_clock        (bit_clock),
    .word_select      (word_select),
    .serial_data      (serial_data)
  );

  initial begin
    clock_50_000_000 = 1'b0;
    forever #20 clock_50_000_000 = ~clock_50_000_000;
  end

  // octave 0 step doubled per octave, upper 16 bits of the phase step
  function automatic sample_t expected_step(input note_t note);
    phase_t inc;
    inc = octave_increment[note % 7'd12] << (note / 7'd12);
    return sample_t'(inc[23:8]);
  endfunction

  function automatic byte_t status_byte(input logic on);
    return {on ? 4'h9 : 4'h8, CHANNEL};
  endfunction

  task automatic drive_bit(input logic level);
    @(posedge clock_50_000_000);
    #2 midi_rx = level;
    repeat (`CLKS_PER_BIT - 1) @(posedge clock_50_000_000);
  endtask

  // returns at the end of the stop bit, just after the parser has acted
  task automatic send_byte(input byte_t value, input logic stop_level);
    drive_bit(1'b1); // idle before the start bit
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(value[i]); // lsb first
    drive_bit(stop_level);
  endtask

  task automatic wait_frames(input int count);
    int target;
    target = frame_check.frames_seen + count;
    while (frame_check.frames_seen < target) @(posedge clock_50_000_000);
  endtask

  task automatic hold_state(input string name);
    frame_check.expect_state(model_sounding,
                             model_sounding ? expected_step(model_note) : '0, name);
    wait_frames(WAIT_FRAMES);
  endtask

  task automatic apply_event(input logic on, input note_t note, input velocity_t vel,
                             input string name);
    if (on && vel != '0) begin
      model_sounding = 1'b1;
      model_note     = note;
    end else if (note == model_note) begin
      model_sounding = 1'b0;
    end
    hold_state(name);
  endtask

  task automatic send_data(input logic on, input note_t note, input velocity_t vel,
                           input string name);
    send_byte({1'b0, note}, 1'b1);
    send_byte({1'b0, vel}, 1'b1);
    apply_event(on, note, vel, name);
  endtask

  task automatic send_note(input logic on, input note_t note, input velocity_t vel,
                           input string name);
    send_byte(status_byte(on), 1'b1);
    send_data(on, note, vel, name);
  endtask

  task automatic print_counts();
    $display("errors: value %0d, framing %0d, other %0d; frames checked %0d",
             frame_check.value_errors, frame_check.frame_errors, other_errors,
             frame_check.checked_frames);
  endtask

  task automatic finish_run();
    int total;
    if (frame_check.checked_frames == 0) begin
      $display("no frames were compared against the reference");
      other_errors++;
    end
    total = frame_check.value_errors + frame_check.frame_errors + other_errors;
    print_counts();
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  always @(posedge clock_50_000_000) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      print_counts();
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    note_t     note;
    velocity_t vel;
    void'($urandom(30145));
    rst     = 1'b1;
    midi_rx = 1'b1;
    repeat (5) @(posedge clock_50_000_000);
    #2 rst = 1'b0;
    wait_frames(WAIT_FRAMES); // silence out of reset

    for (int i = 0; i < 6; i++) begin
      note = note_t'(24 + $urandom % 84);
      vel  = velocity_t'(1 + $urandom % 127);
      send_note(1'b1, note, vel, "note_on");
    end

    send_note(1'b0, model_note + 7'd1, 7'd64, "off_other_note");
    send_note(1'b0, model_note, 7'd64, "off_held_note");
    note = note_t'(36 + $urandom % 48);
    send_note(1'b1, note, 7'd90, "note_on_again");
    send_note(1'b1, note, 7'd0, "velocity_zero_off");

    // second note without a status byte
    send_byte(status_byte(1'b1), 1'b1);
    send_data(1'b1, 7'd60, 7'd100, "running_first");
    send_data(1'b1, 7'd67, 7'd100, "running_second");

    send_byte({4'hB, CHANNEL}, 1'b1);
    send_byte(8'd7, 1'b1);
    send_byte(8'd100, 1'b1);
    hold_state("control_change");
    send_byte({4'h9, OTHER_CHANNEL}, 1'b1);
    send_byte(8'd72, 1'b1);
    send_byte(8'd80, 1'b1);
    hold_state("other_channel");
    send_byte(status_byte(1'b1), 1'b1);
    send_byte(8'd48, 1'b1);
    send_byte(8'hF8, 1'b1); // timing clock in the middle
    send_byte(8'd70, 1'b1);
    apply_event(1'b1, 7'd48, 7'd70, "realtime_between");

    send_note(1'b0, model_note, 7'd64, "off_before_drop");
    send_byte(status_byte(1'b1), 1'b1);
    send_byte(8'd84, 1'b0); // framing error
    send_byte(8'd100, 1'b1);
    hold_state("dropped_byte");
    send_note(1'b0, 7'd84, 7'd64, "resync_off");

    finish_run();
  end

endmodule

// ==== verif/synth_checker.sv ====
`include "synth_defines.svh"

module synth_checker
  import synth_pkg::*;
(
  input logic clock_50_000_000,
  input logic rst,
  input logic bit_clock,
  input logic word_select,
  input logic serial_data
);

  typedef struct packed {
    logic    sounding;
    sample_t step;
  } expect_t;

  expect_t expect_q[$];
  string   name_q[$];
  expect_t cur = '0; // silent after reset
  string   cur_name = "reset_silence";

  int value_errors = 0;
  int frame_errors = 0;
  int frames_seen = 0;
  int checked_frames = 0;

  logic                  bclk_prev;
  logic                  ws_prev;
  logic                  synced;
  logic [`SLOT_BITS-1:0] word;
  int                    bit_count;
  sample_t               left_sample;
  logic                  left_valid;
  sample_t               prev_sample;
  logic                  prev_valid = 1'b0;
  int                    skip = 0;

  task automatic expect_state(input logic sounding, input sample_t step, input string name);
    expect_t item;
    item.sounding = sounding;
    item.step     = step;
    expect_q.push_back(item);
    name_q.push_back(name);
  endtask

  task automatic report_value(input string name, input sample_t expected, input sample_t actual);
    value_errors++;
    $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic check_frame(input sample_t left_value, input sample_t right_value);
    sample_t diff;
    frames_seen++;
    if (expect_q.size() > 0) begin
      cur        = expect_q.pop_front();
      cur_name   = name_q.pop_front();
      skip       = 3; // frames in flight plus the first new one
      prev_valid = 1'b0;
    end
    if (right_value != left_value) report_value({cur_name, "_right"}, left_value, right_value);
    if (skip > 0) begin
      skip--;
    end else if (!cur.sounding) begin
      checked_frames++;
      if (left_value != '0) report_value(cur_name, '0, left_value);
    end else if (prev_valid) begin
      checked_frames++;
      diff = left_value - prev_sample; // wraps mod 2^16
      if (diff != cur.step) report_value(cur_name, cur.step, diff);
    end
    prev_sample = left_value;
    prev_valid  = 1'b1;
  endtask

  task automatic take_slot(input logic [`SLOT_BITS-1:0] slot, input logic right, input int count);
    sample_t value;
    value = slot[`SLOT_BITS-1 -: `SAMPLE_BITS];
    if (count != `SLOT_BITS) begin
      frame_errors++;
      $display("%s slot lasted %0d bit clocks instead of %0d",
               right ? "right" : "left", count, `SLOT_BITS);
    end
    if (slot[`SLOT_BITS-`SAMPLE_BITS-1:0] != '0) begin
      frame_errors++;
      $display("bits after the sample are not zero in the %s slot", right ? "right" : "left");
    end
    if (!right) begin
      left_sample = value;
      left_valid  = 1'b1;
    end else if (left_valid) begin
      check_frame(left_sample, value);
      left_valid = 1'b0;
    end
  endtask

  // i2s deserializer, sampled on the rising bit clock
  always @(posedge clock_50_000_000) begin
    logic [`SLOT_BITS-1:0] slot;
    if (rst) begin
      bclk_prev  = 1'b0;
      ws_prev    = 1'b0;
      synced     = 1'b0;
      word       = '0;
      bit_count  = 0;
      left_valid = 1'b0;
    end else begin
      if (bit_clock && !bclk_prev) begin
        slot = {word[`SLOT_BITS-2:0], serial_data};
        bit_count++;
        if (word_select != ws_prev) begin
          // last bit of a slot comes with the ws edge
          if (synced) take_slot(slot, ws_prev, bit_count);
          synced    = 1'b1;
          word      = '0;
          bit_count = 0;
        end else begin
          word = slot;
        end
        ws_prev = word_select;
      end
      bclk_prev = bit_clock;
    end
  end

endmodule

// ==== verif/synth_props.sv ====
module synth_props
  import synth_pkg::*;
#(
  parameter bit ON_I2S = 1'b0
) (
  input logic    clock_50_000_000,
  input logic    rst,
  input logic    sample_request,
  input logic    bit_clock,
  input logic    word_select,
  input logic    gate,
  input logic    event_valid,
  input logic    note_on,
  input sample_t sample
);

  if (ON_I2S) begin : i2s_checks
    request_single: assert property (
      @(posedge clock_50_000_000) disable iff (rst)
      sample_request |=> !sample_request
    ) else $error("sample_request held high for more than one cycle");

    // ws moves together with the falling bit clock
    ws_on_low_bclk: assert property (
      @(posedge clock_50_000_000) disable iff (rst)
      (word_select != $past(word_select)) |-> !bit_clock
    ) else $error("word_select changed while bit_clock was high");
  end else begin : osc_checks
    // only a note-on opens a closed gate again
    silent_until_note_on: assert property (
      @(posedge clock_50_000_000) disable iff (rst)
      (!gate && !(event_valid && note_on)) |=> (sample == '0)
    ) else $error("nonzero sample with the gate closed and no note-on");
  end

endmodule

bind note_oscillator synth_props #(.ON_I2S(1'b0)) osc_props (
  .clock_50_000_000 (clock_50_000_000),
  .rst              (rst),
  .sample_request   (sample_request),
  .bit_clock        (1'b0),
  .word_select      (1'b0),
  .gate             (gate),
  .event_valid      (event_valid),
  .note_on          (note_event.on),
  .sample           (sample)
);

bind i2s_transmitter synth_props #(.ON_I2S(1'b1)) i2s_props (
  .clock_50_000_000 (clock_50_000_000),
  .rst              (rst),
  .sample_request   (sample_request),
  .bit_clock        (bit_clock),
  .word_select      (word_select),
  .gate             (1'b1),
  .event_valid      (1'b0),
  .note_on          (1'b0),
  .sample           ('0)
);

// ==== source/synth_top.sv ====
module synth_top
  import synth_pkg::*;
(
  input  logic clock_50_000_000,
  input  logic rst,
  input  logic midi_rx,
  output logic bit_clock,
  output logic word_select,
  output logic serial_data
);

  byte_t       rx_byte;
  logic        rx_valid;
  note_event_t note_event;
  logic        event_valid;
  sample_t     sample;
  logic        sample_request;

  uart_receiver uart_receiver (
    .clock_50_000_000,
    .rst,
    .rx       (midi_rx),
    .rx_byte,
    .rx_valid
  );

  midi_parser midi_parser (
    .clock_50_000_000,
    .rst,
    .rx_byte,
    .rx_valid,
    .note_event,
    .event_valid
  );

  note_oscillator note_oscillator (
    .clock_50_000_000,
    .rst,
    .note_event,
    .event_valid,
    .sample_request,
    .sample
  );

  // one sample per frame, same value on both channels
  i2s_transmitter i2s_transmitter (
    .clock_50_000_000,
    .rst,
    .sample,
    .sample_request,
    .bit_clock,
    .word_select,
    .serial_data
  );

endmodule

// ==== source/i2s_transmitter.sv ====
`include "synth_defines.svh"

module i2s_transmitter
  import synth_pkg::*;
(
  input  logic    clock_50_000_000,
  input  logic    rst,
  input  sample_t sample,
  output logic    sample_request,
  output logic    bit_clock,
  output logic    word_select,
  output logic    serial_data
);

  localparam int DIV_W = $clog2(`BCLK_DIV);
  localparam int POS_W = $clog2(`SLOT_BITS);

  logic [DIV_W-1:0]      div_count;
  logic [POS_W-1:0]      bit_pos;
  logic                  fall;
  logic                  last_pos;
  sample_t               sample_hold;
  logic [`SLOT_BITS-1:0] shifter;

  assign fall     = bit_clock && (div_count == DIV_W'(`BCLK_DIV - 1));
  assign last_pos = (bit_pos == POS_W'(`SLOT_BITS - 1));

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      div_count <= '0;
      bit_clock <= 1'b0;
    end else if (div_count == DIV_W'(`BCLK_DIV - 1)) begin
      div_count <= '0;
      bit_clock <= ~bit_clock;
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  // everything below moves on the bit clock falling edge
  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      bit_pos        <= '0;
      word_select    <= 1'b0;
      serial_data    <= 1'b0;
      sample_request <= 1'b0;
      sample_hold    <= '0;
      shifter        <= '0;
    end else begin
      sample_request <= 1'b0;
      if (sample_request) sample_hold <= sample;
      if (fall) begin
        if (last_pos) begin
          bit_pos        <= '0;
          word_select    <= ~word_select;
          sample_request <= word_select; // right slot done, new frame
        end else begin
          bit_pos <= bit_pos + 1'b1;
        end
        if (bit_pos == '0) begin
          // msb goes out one bit clock after the ws edge
          serial_data <= sample_hold[`SAMPLE_BITS-1];
          shifter     <= {sample_hold, {(`SLOT_BITS - `SAMPLE_BITS){1'b0}}} << 1;
        end else begin
          serial_data <= shifter[`SLOT_BITS-1];
          shifter     <= shifter << 1;
        end
      end
    end
  end

endmodule

// ==== source/note_oscillator.sv ====
`include "synth_defines.svh"

module note_oscillator
  import synth_pkg::*;
(
  input  logic        clock_50_000_000,
  input  logic        rst,
  input  note_event_t note_event,
  input  logic        event_valid,
  input  logic        sample_request,
  output sample_t     sample
);

  logic       gate;
  note_t      held_note;
  phase_t     phase;
  logic [3:0] semitone;
  logic [3:0] octave;
  phase_t     step;

  // octave rule, table entry doubled once per octave
  assign semitone = 4'(held_note % 7'd12);
  assign octave   = 4'(held_note / 7'd12);
  assign step     = octave_increment[semitone] << octave;

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      gate      <= 1'b0;
      held_note <= '0;
    end else if (event_valid) begin
      if (note_event.on) begin
        gate      <= 1'b1;
        held_note <= note_event.note;
      end else if (note_event.note == held_note) begin
        gate <= 1'b0; // off for another note is ignored
      end
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      phase <= '0;
    end else if (event_valid && note_event.on) begin
      phase <= '0; // restart the ramp on every note-on
    end else if (sample_request && gate) begin
      phase <= phase + step;
    end
  end

  // current sample is read before the phase advances
  assign sample = gate ? sample_t'(phase[$bits(phase_t)-1 -: `SAMPLE_BITS]) : '0;

endmodule

// ==== source/midi_parser.sv ====
`include "synth_defines.svh"

module midi_parser
  import synth_pkg::*;
(
  input  logic        clock_50_000_000,
  input  logic        rst,
  input  byte_t       rx_byte,
  input  logic        rx_valid,
  output note_event_t note_event,
  output logic        event_valid
);

  parse_state_t state;
  logic         status_valid; // running status held
  logic         status_on;    // 1 for note-on, 0 for note-off
  note_t        data1;
  logic         is_realtime;
  logic         is_status;
  logic         is_note_status;

  assign is_realtime    = rx_byte >= 8'hF8;
  assign is_status      = rx_byte[7];
  assign is_note_status = (rx_byte[7:4] == 4'h8 || rx_byte[7:4] == 4'h9) &&
                          (rx_byte[3:0] == 4'(`MIDI_CHANNEL));

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      state        <= idle;
      status_valid <= 1'b0;
      status_on    <= 1'b0;
      event_valid  <= 1'b0;
    end else begin
      event_valid <= 1'b0;
      if (rx_valid && !is_realtime) begin
        if (is_status) begin
          status_valid <= is_note_status;
          status_on    <= rx_byte[4];
          state        <= is_note_status ? wait_data1 : idle;
        end else begin
          case (state)
            idle: begin
              if (status_valid) state <= wait_data2; // running status
            end
            wait_data1: state <= wait_data2;
            wait_data2: begin
              event_valid <= 1'b1;
              state       <= idle;
            end
            default: state <= idle;
          endcase
        end
      end
    end
  end

  // note number and event payload
  always_ff @(posedge clock_50_000_000) begin
    if (rx_valid && !is_status) begin
      if (state == wait_data1 || (state == idle && status_valid)) data1 <= rx_byte[6:0];
      if (state == wait_data2) begin
        note_event.on       <= status_on && (rx_byte[6:0] != '0); // vel 0 is off
        note_event.note     <= data1;
        note_event.velocity <= rx_byte[6:0];
      end
    end
  end

endmodule

// ==== source/uart_receiver.sv ====
`include "synth_defines.svh"

module uart_receiver
  import synth_pkg::*;
(
  input  logic  clock_50_000_000,
  input  logic  rst,
  input  logic  rx,
  output byte_t rx_byte,
  output logic  rx_valid
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);
  // half a bit, less the synchronizer and edge detect delay
  localparam int HALF_LOAD = `CLKS_PER_BIT / 2 - 4;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy;
  logic [3:0]       bit_index; // 0 start, 1..8 data, 9 stop
  logic [CNT_W-1:0] clk_count;
  byte_t            shift_reg;
  logic             sample_now;

  assign sample_now = busy && (clk_count == '0);

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    if (rst) begin
      busy      <= 1'b0;
      bit_index <= '0;
      clk_count <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (rx_prev && !rx_sync) begin // falling edge, start bit
          busy      <= 1'b1;
          bit_index <= '0;
          clk_count <= CNT_W'(HALF_LOAD);
        end
      end else if (clk_count != '0) begin
        clk_count <= clk_count - 1'b1;
      end else begin
        clk_count <= CNT_W'(`CLKS_PER_BIT - 1);
        bit_index <= bit_index + 1'b1;
        if (bit_index == 4'd0) begin
          if (rx_sync) busy <= 1'b0; // glitch, not a real start bit
        end else if (bit_index == 4'd9) begin
          busy     <= 1'b0;
          rx_valid <= rx_sync; // low stop bit drops the byte
        end
      end
    end
  end

  always_ff @(posedge clock_50_000_000) begin
    if (sample_now) begin
      if (bit_index >= 4'd1 && bit_index <= 4'd8) shift_reg <= {rx_sync, shift_reg[7:1]};
      if (bit_index == 4'd9 && rx_sync) rx_byte <= shift_reg;
    end
  end

endmodule

// ==== source/synth_pkg.sv ====
`include "synth_defines.svh"

package synth_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] note_t;
  typedef logic [6:0] velocity_t;
  typedef logic signed [`SAMPLE_BITS-1:0] sample_t;
  typedef logic [23:0] phase_t;

  typedef struct packed {
    logic      on;
    note_t     note;
    velocity_t velocity;
  } note_event_t;

  typedef enum logic [1:0] {
    idle,
    wait_data1,
    wait_data2
  } parse_state_t;

  // per-sample phase step of octave 0, C to B
  // low byte kept zero so the 16-bit sample step is exact
  localparam phase_t octave_increment [12] = '{
    24'h000B00, 24'h000C00, 24'h000C00, 24'h000D00,
    24'h000E00, 24'h000F00, 24'h001000, 24'h001000,
    24'h001100, 24'h001200, 24'h001400, 24'h001500
  };

endpackage

// ==== source/synth_defines.svh ====
`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

// 50 MHz / 31250 baud
`define CLKS_PER_BIT 1600

// half period of the i2s bit clock, in system clocks
`define BCLK_DIV 8

// listened midi channel, 0 to 15
`define MIDI_CHANNEL 0

`define SAMPLE_BITS 16

`define SLOT_BITS 32 // bits per i2s channel slot

`endif
